/* all.f */
source/rv_isa_pkg.sv
source/exec_ctrl_pkg.sv
source/exec_pipe_reg.sv
source/exec_decode.sv
source/exec_alu.sv
source/exec_resolve.sv
source/riscv_execute.sv
testbench/tb_exec_model.sv
testbench/tb_riscv_execute.sv

/* source/exec_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_alu
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire             i_clk,
    input  wire             rst_i,

    input  wire             in_valid_i,
    output logic            in_ready_o,
    input  alu_fn_t         alu_fn_i,
    input  src_a_sel_t      src_a_sel_i,
    input  src_b_sel_t      src_b_sel_i,
    input  tgt_base_t       tgt_base_i,
    input  wire             is_branch_i,
    input  wire             is_jump_i,
    input  wire             wb_en_i,
    input  wire [XLEN-1:0]  rs1_data_i,
    input  wire [XLEN-1:0]  rs2_data_i,
    input  wire [XLEN-1:0]  imm_i,
    input  wire [XLEN-1:0]  pc_i,

    output logic            out_valid_o,
    input  wire             out_ready_i,
    output logic [XLEN-1:0] alu_result_o,
    output logic [XLEN-1:0] target_o,
    output logic [XLEN-1:0] pc_o,
    output logic            is_branch_o,
    output logic            is_jump_o,
    output logic            wb_en_o
);

    typedef struct packed {
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] target;
        logic            is_branch;
        logic            is_jump;
        logic            wb_en;
        logic [XLEN-1:0] pc;
    } alu_payload_t;

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_res;
    logic [XLEN-1:0]    tgt_sum;
    logic [XLEN-1:0]    tgt_addr;
    alu_payload_t       alu_d;
    alu_payload_t       alu_q;

    // ========================================
    // Operands and function.
    // ========================================
    always_comb begin
        case (src_a_sel_i)
            SRC_A_PC:   op_a = pc_i;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_data_i;
        endcase
    end

    assign op_b  = (src_b_sel_i == SRC_B_IMM) ? imm_i : rs2_data_i;
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (alu_fn_i)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $unsigned($signed(op_a) >>> shamt);
            ALU_SLT:  alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_res = XLEN'(op_a < op_b);
            ALU_EQ:   alu_res = XLEN'(op_a == op_b);
            ALU_NE:   alu_res = XLEN'(op_a != op_b);
            ALU_GE:   alu_res = XLEN'($signed(op_a) >= $signed(op_b));
            ALU_GEU:  alu_res = XLEN'(op_a >= op_b);
            default:  alu_res = op_a + op_b;
        endcase
    end

    // Target adder, separate from the ALU.
    assign tgt_sum  = ((tgt_base_i == TGT_RS1) ? rs1_data_i : pc_i) + imm_i;
    assign tgt_addr = (tgt_base_i == TGT_RS1) ? {tgt_sum[XLEN-1:1], 1'b0} : tgt_sum;

    assign alu_d = '{
        alu_result: alu_res,
        target:     tgt_addr,
        is_branch:  is_branch_i,
        is_jump:    is_jump_i,
        wb_en:      wb_en_i,
        pc:         pc_i
    };

    exec_pipe_reg #(
        .payload_t (alu_payload_t)
    ) u_alu_reg (
        .i_clk       (i_clk),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (alu_d),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (alu_q)
    );

    assign alu_result_o = alu_q.alu_result;
    assign target_o     = alu_q.target;
    assign pc_o         = alu_q.pc;
    assign is_branch_o  = alu_q.is_branch;
    assign is_jump_o    = alu_q.is_jump;
    assign wb_en_o      = alu_q.wb_en;

endmodule

`default_nettype wire

/* source/exec_ctrl_pkg.sv */
`default_nettype none

package exec_ctrl_pkg;

    // ========================================
    // Decode outputs consumed by later stages.
    // ========================================
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,    // Signed less than.
        ALU_SLTU,
        ALU_EQ,
        ALU_NE,
        ALU_GE,     // Signed.
        ALU_GEU
    } alu_fn_t;

    typedef enum logic [1:0] {
        SRC_A_RS1,
        SRC_A_PC,
        SRC_A_ZERO  // For LUI.
    } src_a_sel_t;

    typedef enum logic {
        SRC_B_RS2,
        SRC_B_IMM
    } src_b_sel_t;

    typedef enum logic {TGT_PC, TGT_RS1} tgt_base_t;

endpackage

`default_nettype wire

/* source/exec_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_decode
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire             i_clk,
    input  wire             rst_i,

    input  wire             in_valid_i,
    output logic            in_ready_o,
    input  exec_op_t        op_i,
    input  wire [XLEN-1:0]  rs1_data_i,
    input  wire [XLEN-1:0]  rs2_data_i,
    input  wire [XLEN-1:0]  imm_i,
    input  wire [XLEN-1:0]  pc_i,

    output logic            out_valid_o,
    input  wire             out_ready_i,
    output alu_fn_t         alu_fn_o,
    output src_a_sel_t      src_a_sel_o,
    output src_b_sel_t      src_b_sel_o,
    output tgt_base_t       tgt_base_o,
    output logic            is_branch_o,
    output logic            is_jump_o,
    output logic            wb_en_o,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    output logic [XLEN-1:0] imm_o,
    output logic [XLEN-1:0] pc_o
);

    typedef struct packed {
        alu_fn_t          alu_fn;
        src_a_sel_t       src_a_sel;
        src_b_sel_t       src_b_sel;
        tgt_base_t        tgt_base;
        logic             is_branch;
        logic             is_jump;
        logic             wb_en;
        logic [XLEN-1:0]  rs1_data;
        logic [XLEN-1:0]  rs2_data;
        logic [XLEN-1:0]  imm;
        logic [XLEN-1:0]  pc;
    } dec_payload_t;

    dec_payload_t dec_d;
    dec_payload_t dec_q;

    // ========================================
    // Operation to control set.
    // ========================================
    always_comb begin
        dec_d           = '0;
        dec_d.rs1_data  = rs1_data_i;
        dec_d.rs2_data  = rs2_data_i;
        dec_d.imm       = imm_i;
        dec_d.pc        = pc_i;
        dec_d.src_a_sel = SRC_A_RS1;
        dec_d.src_b_sel = SRC_B_IMM;
        dec_d.tgt_base  = TGT_PC;
        dec_d.wb_en     = 1'b1;

        case (op_i)
            OP_SUB:                dec_d.alu_fn = ALU_SUB;
            OP_XOR, OP_XORI:       dec_d.alu_fn = ALU_XOR;
            OP_OR, OP_ORI:         dec_d.alu_fn = ALU_OR;
            OP_AND, OP_ANDI:       dec_d.alu_fn = ALU_AND;
            OP_SLL, OP_SLLI:       dec_d.alu_fn = ALU_SLL;
            OP_SRL, OP_SRLI:       dec_d.alu_fn = ALU_SRL;
            OP_SRA, OP_SRAI:       dec_d.alu_fn = ALU_SRA;
            OP_SLT, OP_SLTI, OP_BLT:     dec_d.alu_fn = ALU_SLT;
            OP_SLTU, OP_SLTIU, OP_BLTU:  dec_d.alu_fn = ALU_SLTU;
            OP_BEQ:                dec_d.alu_fn = ALU_EQ;
            OP_BNE:                dec_d.alu_fn = ALU_NE;
            OP_BGE:                dec_d.alu_fn = ALU_GE;
            OP_BGEU:               dec_d.alu_fn = ALU_GEU;
            default:               dec_d.alu_fn = ALU_ADD;   // Address and link math.
        endcase

        case (op_i)
            OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND,
            OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU: begin
                dec_d.src_b_sel = SRC_B_RS2;
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                dec_d.tgt_base = TGT_RS1;
            end
            OP_SB, OP_SH, OP_SW: begin
                dec_d.tgt_base = TGT_RS1;
                dec_d.wb_en    = 1'b0;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                dec_d.src_b_sel = SRC_B_RS2;   // Compare rs1 with rs2.
                dec_d.is_branch = 1'b1;
                dec_d.wb_en     = 1'b0;
            end
            OP_JAL: begin
                dec_d.src_a_sel = SRC_A_PC;
                dec_d.is_jump   = 1'b1;
            end
            OP_JALR: begin
                dec_d.tgt_base = TGT_RS1;
                dec_d.is_jump  = 1'b1;
            end
            OP_LUI:   dec_d.src_a_sel = SRC_A_ZERO;
            OP_AUIPC: dec_d.src_a_sel = SRC_A_PC;
            default: ;
        endcase
    end

    exec_pipe_reg #(
        .payload_t (dec_payload_t)
    ) u_dec_reg (
        .i_clk       (i_clk),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (dec_d),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (dec_q)
    );

    assign alu_fn_o    = dec_q.alu_fn;
    assign src_a_sel_o = dec_q.src_a_sel;
    assign src_b_sel_o = dec_q.src_b_sel;
    assign tgt_base_o  = dec_q.tgt_base;
    assign is_branch_o = dec_q.is_branch;
    assign is_jump_o   = dec_q.is_jump;
    assign wb_en_o     = dec_q.wb_en;
    assign rs1_data_o  = dec_q.rs1_data;
    assign rs2_data_o  = dec_q.rs2_data;
    assign imm_o       = dec_q.imm;
    assign pc_o        = dec_q.pc;

endmodule

`default_nettype wire

/* source/exec_pipe_reg.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire      i_clk,
    input  wire      rst_i,

    input  wire      in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  wire      out_ready_i,
    output payload_t out_data_o
);

    logic     valid_q;
    payload_t data_q;

    // Room when empty or when the held entry leaves this cycle.
    assign in_ready_o = !valid_q || out_ready_i;

    always_ff @(posedge i_clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;   // Load, refill or drain.
        end
    end

    always_ff @(posedge i_clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = valid_q;
    assign out_data_o  = data_q;

endmodule

`default_nettype wire

/* source/exec_resolve.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_resolve
    import rv_isa_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire             i_clk,
    input  wire             rst_i,

    input  wire             in_valid_i,
    output logic            in_ready_o,
    input  wire [XLEN-1:0]  alu_result_i,
    input  wire [XLEN-1:0]  target_i,
    input  wire [XLEN-1:0]  pc_i,
    input  wire             is_branch_i,
    input  wire             is_jump_i,
    input  wire             wb_en_i,

    output logic            out_valid_o,
    input  wire             out_ready_i,
    output logic [XLEN-1:0] result_o,
    output logic [XLEN-1:0] target_o,
    output logic            branch_taken_o,
    output logic            jump_o,
    output logic            wb_en_o
);

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] target;
        logic            branch_taken;
        logic            jump;
        logic            wb_en;
    } res_payload_t;

    res_payload_t res_d;
    res_payload_t res_q;

    // Jumps write the link address, everything else the ALU value.
    assign res_d.result       = is_jump_i ? pc_i + XLEN'(PC_STEP) : alu_result_i;
    assign res_d.target       = target_i;
    assign res_d.branch_taken = is_branch_i & alu_result_i[0];   // Compare bit.
    assign res_d.jump         = is_jump_i;
    assign res_d.wb_en        = wb_en_i;

    exec_pipe_reg #(
        .payload_t (res_payload_t)
    ) u_res_reg (
        .i_clk       (i_clk),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (res_d),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (res_q)
    );

    assign result_o       = res_q.result;
    assign target_o       = res_q.target;
    assign branch_taken_o = res_q.branch_taken;
    assign jump_o         = res_q.jump;
    assign wb_en_o        = res_q.wb_en;

endmodule

`default_nettype wire

/* source/riscv_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module riscv_execute
    import rv_isa_pkg::*;
    import exec_ctrl_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  wire             i_clk,
    input  wire             rst_i,

    input  wire             in_valid_i,
    output logic            in_ready_o,
    input  exec_op_t        op_i,
    input  wire [XLEN-1:0]  rs1_data_i,
    input  wire [XLEN-1:0]  rs2_data_i,
    input  wire [XLEN-1:0]  imm_i,
    input  wire [XLEN-1:0]  pc_i,

    output logic            out_valid_o,
    input  wire             out_ready_i,
    output logic [XLEN-1:0] result_o,
    output logic [XLEN-1:0] target_o,
    output logic            branch_taken_o,
    output logic            jump_o,
    output logic            wb_en_o
);

    // ========================================
    // Decode to ALU.
    // ========================================
    logic            dec_valid;
    logic            dec_ready;
    alu_fn_t         dec_alu_fn;
    src_a_sel_t      dec_src_a_sel;
    src_b_sel_t      dec_src_b_sel;
    tgt_base_t       dec_tgt_base;
    logic            dec_is_branch;
    logic            dec_is_jump;
    logic            dec_wb_en;
    logic [XLEN-1:0] dec_rs1_data;
    logic [XLEN-1:0] dec_rs2_data;
    logic [XLEN-1:0] dec_imm;
    logic [XLEN-1:0] dec_pc;

    // ========================================
    // ALU to resolve.
    // ========================================
    logic            alu_valid;
    logic            alu_ready;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] alu_target;
    logic [XLEN-1:0] alu_pc;
    logic            alu_is_branch;
    logic            alu_is_jump;
    logic            alu_wb_en;

    exec_decode #(
        .XLEN (XLEN)
    ) u_decode (
        .i_clk       (i_clk),
        .rst_i       (rst_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .op_i        (op_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .imm_i       (imm_i),
        .pc_i        (pc_i),
        .out_valid_o (dec_valid),
        .out_ready_i (dec_ready),
        .alu_fn_o    (dec_alu_fn),
        .src_a_sel_o (dec_src_a_sel),
        .src_b_sel_o (dec_src_b_sel),
        .tgt_base_o  (dec_tgt_base),
        .is_branch_o (dec_is_branch),
        .is_jump_o   (dec_is_jump),
        .wb_en_o     (dec_wb_en),
        .rs1_data_o  (dec_rs1_data),
        .rs2_data_o  (dec_rs2_data),
        .imm_o       (dec_imm),
        .pc_o        (dec_pc)
    );

    exec_alu #(
        .XLEN (XLEN)
    ) u_alu (
        .i_clk        (i_clk),
        .rst_i        (rst_i),
        .in_valid_i   (dec_valid),
        .in_ready_o   (dec_ready),
        .alu_fn_i     (dec_alu_fn),
        .src_a_sel_i  (dec_src_a_sel),
        .src_b_sel_i  (dec_src_b_sel),
        .tgt_base_i   (dec_tgt_base),
        .is_branch_i  (dec_is_branch),
        .is_jump_i    (dec_is_jump),
        .wb_en_i      (dec_wb_en),
        .rs1_data_i   (dec_rs1_data),
        .rs2_data_i   (dec_rs2_data),
        .imm_i        (dec_imm),
        .pc_i         (dec_pc),
        .out_valid_o  (alu_valid),
        .out_ready_i  (alu_ready),
        .alu_result_o (alu_result),
        .target_o     (alu_target),
        .pc_o         (alu_pc),
        .is_branch_o  (alu_is_branch),
        .is_jump_o    (alu_is_jump),
        .wb_en_o      (alu_wb_en)
    );

    exec_resolve #(
        .XLEN (XLEN)
    ) u_resolve (
        .i_clk          (i_clk),
        .rst_i          (rst_i),
        .in_valid_i     (alu_valid),
        .in_ready_o     (alu_ready),
        .alu_result_i   (alu_result),
        .target_i       (alu_target),
        .pc_i           (alu_pc),
        .is_branch_i    (alu_is_branch),
        .is_jump_i      (alu_is_jump),
        .wb_en_i        (alu_wb_en),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .result_o       (result_o),
        .target_o       (target_o),
        .branch_taken_o (branch_taken_o),
        .jump_o         (jump_o),
        .wb_en_o        (wb_en_o)
    );

endmodule

`default_nettype wire

/* source/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // ========================================
    // Operations handled by the execute stage.
    // ========================================
    typedef enum logic [5:0] {
        // Register-register ALU.
        OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        // Register-immediate ALU.
        OP_ADDI, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        // Loads and stores.
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        // Conditional branches.
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        // Jumps and upper immediates.
        OP_JAL, OP_JALR,
        OP_LUI, OP_AUIPC
    } exec_op_t;

    // Bytes per instruction, the link offset.
    localparam int PC_STEP = 4;

    // Only the low bits of a shift operand count.
    localparam int SHAMT_W = 5;

endpackage

`default_nettype wire

/* testbench/tb_exec_model.sv */
`default_nettype none

package tb_exec_model;

    import rv_isa_pkg::*;

    // Expected outputs of one instruction, with flags for the fields that are defined.
    typedef struct packed {
        logic [31:0] result;
        logic [31:0] target;
        logic        chk_result;
        logic        chk_target;
        logic        taken;
        logic        jump;
        logic        wb_en;
    } exp_t;

    // Signed order from the sign bits first, then the magnitude.
    function automatic logic lt_signed(logic [31:0] a, logic [31:0] b);
        if (a[31] != b[31]) begin
            return a[31];
        end
        return a < b;
    endfunction

    // Logical shift with the vacated bits filled from the sign.
    function automatic logic [31:0] shift_right_arith(logic [31:0] a, logic [4:0] sh);
        logic [31:0] fill;
        fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0;
        return (a >> sh) | fill;
    endfunction

    function automatic exp_t model_exec(exec_op_t op, logic [31:0] rs1, logic [31:0] rs2,
                                        logic [31:0] imm, logic [31:0] pc);
        exp_t e;
        e            = '0;
        e.chk_result = 1'b1;
        e.wb_en      = 1'b1;
        case (op)
            OP_ADD:   e.result = rs1 + rs2;
            OP_SUB:   e.result = rs1 - rs2;
            OP_XOR:   e.result = rs1 ^ rs2;
            OP_OR:    e.result = rs1 | rs2;
            OP_AND:   e.result = rs1 & rs2;
            OP_SLL:   e.result = rs1 << rs2[4:0];
            OP_SRL:   e.result = rs1 >> rs2[4:0];
            OP_SRA:   e.result = shift_right_arith(rs1, rs2[4:0]);
            OP_SLT:   e.result = {31'b0, lt_signed(rs1, rs2)};
            OP_SLTU:  e.result = {31'b0, rs1 < rs2};
            OP_ADDI:  e.result = rs1 + imm;
            OP_XORI:  e.result = rs1 ^ imm;
            OP_ORI:   e.result = rs1 | imm;
            OP_ANDI:  e.result = rs1 & imm;
            OP_SLLI:  e.result = rs1 << imm[4:0];
            OP_SRLI:  e.result = rs1 >> imm[4:0];
            OP_SRAI:  e.result = shift_right_arith(rs1, imm[4:0]);
            OP_SLTI:  e.result = {31'b0, lt_signed(rs1, imm)};
            OP_SLTIU: e.result = {31'b0, rs1 < imm};
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: e.result = rs1 + imm;
            OP_SB, OP_SH, OP_SW: begin
                e.result = rs1 + imm;
                e.wb_en  = 1'b0;
            end
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                e.chk_result = 1'b0;   // No register value for branches.
                e.chk_target = 1'b1;
                e.target     = pc + imm;
                e.wb_en      = 1'b0;
                case (op)
                    OP_BEQ:  e.taken = (rs1 == rs2);
                    OP_BNE:  e.taken = (rs1 != rs2);
                    OP_BLT:  e.taken = lt_signed(rs1, rs2);
                    OP_BGE:  e.taken = !lt_signed(rs1, rs2);
                    OP_BLTU: e.taken = (rs1 < rs2);
                    default: e.taken = !(rs1 < rs2);
                endcase
            end
            OP_JAL, OP_JALR: begin
                e.result     = pc + 32'd4;
                e.chk_target = 1'b1;
                e.jump       = 1'b1;
                e.target     = (op == OP_JAL) ? pc + imm : (rs1 + imm) & ~32'h1;
            end
            OP_LUI:   e.result = imm;
            OP_AUIPC: e.result = pc + imm;
            default:  e = '0;
        endcase
        return e;
    endfunction

endpackage

`default_nettype wire

/* testbench/tb_riscv_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_riscv_execute
    import rv_isa_pkg::*;
    import tb_exec_model::*;
();

    localparam int XLEN     = 32;
    localparam int LATENCY  = 3;
    localparam int MAX_WAIT = 60;   // Cycles per wait loop.

    typedef struct packed {
        exp_t        exp;
        logic [31:0] stamp;     // Cycle of the input transfer.
        logic        lat_chk;
    } sb_entry_t;

    logic            i_clk;
    logic            rst_i;
    logic            in_valid_i;
    logic            in_ready_o;
    exec_op_t        op_i;
    logic [XLEN-1:0] rs1_data_i;
    logic [XLEN-1:0] rs2_data_i;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] pc_i;
    logic            out_valid_o;
    logic            out_ready_i = 1'b1;
    logic [XLEN-1:0] result_o;
    logic [XLEN-1:0] target_o;
    logic            branch_taken_o;
    logic            jump_o;
    logic            wb_en_o;

    sb_entry_t   exp_q[$];
    sb_entry_t   head      = '0;
    int          held_cnt  = 0;
    logic [31:0] cycle_cnt = '0;
    logic        bp_mode   = 1'b0;
    int          err_cnt   = 0;
    int          chk_cnt   = 0;
    int          test_err0 = 0;
    int          test_chk0 = 0;
    logic        out_fire;

    riscv_execute #(
        .XLEN (XLEN)
    ) DUT (
        .i_clk          (i_clk),
        .rst_i          (rst_i),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .op_i           (op_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .imm_i          (imm_i),
        .pc_i           (pc_i),
        .out_valid_o    (out_valid_o),
        .out_ready_i    (out_ready_i),
        .result_o       (result_o),
        .target_o       (target_o),
        .branch_taken_o (branch_taken_o),
        .jump_o         (jump_o),
        .wb_en_o        (wb_en_o)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Ready is low two cycles out of three in back-pressure mode.
    always @(posedge i_clk) begin
        out_ready_i <= bp_mode ? ($urandom_range(0, 2) == 0) : 1'b1;
    end

    assign out_fire = out_valid_o && out_ready_i;

    // ========================================
    // Scoreboard.
    // ========================================
    always @(posedge i_clk) begin
        sb_entry_t ent;
        cycle_cnt <= cycle_cnt + 1;
        if (!rst_i) begin
            if (out_fire && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                chk_cnt++;
            end
            if (in_valid_i && in_ready_o) begin
                ent.exp     = model_exec(op_i, rs1_data_i, rs2_data_i, imm_i, pc_i);
                ent.stamp   = cycle_cnt;
                ent.lat_chk = !bp_mode;
                exp_q.push_back(ent);
            end
        end else begin
            exp_q.delete();   // Reset flushes the pipeline.
        end
        head     <= (exp_q.size() > 0) ? exp_q[0] : '0;
        held_cnt <= exp_q.size();   // Entries inside the pipe next cycle.
    end

    task automatic log_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic log_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // ========================================
    // Checks.
    // ========================================
    a_no_extra: assert property (@(posedge i_clk) disable iff (rst_i)
        out_fire |-> held_cnt > 0)
        else log_failure("an output came out with no instruction outstanding");

    a_result: assert property (@(posedge i_clk) disable iff (rst_i)
        out_fire && head.exp.chk_result |-> result_o == head.exp.result)
        else log_mismatch($sformatf("result %h, expected %h",
                                    $sampled(result_o), $sampled(head.exp.result)));

    a_target: assert property (@(posedge i_clk) disable iff (rst_i)
        out_fire && head.exp.chk_target |-> target_o == head.exp.target)
        else log_mismatch($sformatf("target %h, expected %h",
                                    $sampled(target_o), $sampled(head.exp.target)));

    a_flags: assert property (@(posedge i_clk) disable iff (rst_i)
        out_fire |-> {branch_taken_o, jump_o, wb_en_o} ==
                     {head.exp.taken, head.exp.jump, head.exp.wb_en})
        else log_mismatch("branch_taken, jump or wb_en differs from the model");

    a_latency: assert property (@(posedge i_clk) disable iff (rst_i)
        out_fire && head.lat_chk |-> cycle_cnt - head.stamp == LATENCY)
        else log_mismatch($sformatf("latency %0d cycles, expected %0d",
                                    $sampled(cycle_cnt - head.stamp), LATENCY));

    a_hold: assert property (@(posedge i_clk) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o)
            && $stable(target_o) && $stable({branch_taken_o, jump_o, wb_en_o}))
        else log_failure("a stalled output changed before it was taken");

    a_full: assert property (@(posedge i_clk) disable iff (rst_i)
        !in_ready_o |-> held_cnt == 3)
        else log_failure("in_ready_o dropped with fewer than three instructions held");

    a_reset: assert property (@(posedge i_clk)
        rst_i |=> !out_valid_o && in_ready_o)
        else log_failure("the pipeline was not empty and ready after reset");

    // ========================================
    // Stimulus.
    // ========================================
    function automatic logic [31:0] rand_word();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'hFFFF_FFFF;
            3:       return 32'h7FFF_FFFF;
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [31:0] rand_imm(input exec_op_t op);
        logic [31:0] r;
        r = $urandom;
        if (op inside {OP_LUI, OP_AUIPC}) begin
            return {r[31:12], 12'h000};
        end else if (op inside {[OP_BEQ:OP_BGEU]}) begin
            return {{19{r[12]}}, r[12:1], 1'b0};
        end else if (op == OP_JAL) begin
            return {{11{r[20]}}, r[20:1], 1'b0};
        end
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // Called just after a rising edge; returns on the edge of the transfer.
    task automatic send_op(input exec_op_t op, input logic [31:0] rs1, input logic [31:0] rs2,
                           input logic [31:0] imm, input logic [31:0] pc);
        int waited;
        in_valid_i <= 1'b1;
        op_i       <= op;
        rs1_data_i <= rs1;
        rs2_data_i <= rs2;
        imm_i      <= imm;
        pc_i       <= pc;
        waited = 0;
        do begin
            @(posedge i_clk);
            waited++;
        end while (!in_ready_o && waited < MAX_WAIT);
        if (!in_ready_o) begin
            log_failure("the DUT did not accept an instruction in time");
        end
        in_valid_i <= 1'b0;
    endtask

    task automatic idle(input int cycles);
        in_valid_i <= 1'b0;
        repeat (cycles) @(posedge i_clk);
    endtask

    task automatic run_group(input exec_op_t first, input exec_op_t last, input int count,
                             input int gap_max);
        exec_op_t    op;
        logic [31:0] rs1;
        logic [31:0] rs2;
        for (int i = 0; i < count; i++) begin
            op  = exec_op_t'($urandom_range(int'(last), int'(first)));
            rs1 = rand_word();
            rs2 = rand_word();
            if (op inside {[OP_BEQ:OP_BGEU]} && $urandom_range(0, 3) == 0) begin
                rs2 = rs1;   // Equal operands.
            end
            send_op(op, rs1, rs2, rand_imm(op), $urandom & 32'hFFFF_FFFC);
            if (gap_max > 0) begin
                idle($urandom_range(0, gap_max));
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        do begin
            @(posedge i_clk);
            waited++;
        end while (held_cnt != 0 && waited < MAX_WAIT);
        if (held_cnt != 0) begin
            log_failure($sformatf("%0d results never left the pipeline", exp_q.size()));
            exp_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        $display("%-30s %0d results checked, %0d errors",
                 name, chk_cnt - test_chk0, err_cnt - test_err0);
        test_chk0 = chk_cnt;
        test_err0 = err_cnt;
    endtask

    initial begin
        void'($urandom(61329));
        rst_i      = 1'b1;
        in_valid_i = 1'b0;
        op_i       = OP_ADD;
        rs1_data_i = '0;
        rs2_data_i = '0;
        imm_i      = '0;
        pc_i       = '0;
        repeat (3) @(posedge i_clk);
        rst_i <= 1'b0;

        run_group(OP_ADD, OP_SLTIU, 300, 0);
        wait_drain();
        finish_test("register and immediate ALU");

        run_group(OP_LB, OP_SW, 150, 0);
        wait_drain();
        finish_test("loads and stores");

        run_group(OP_BEQ, OP_BGEU, 200, 0);
        wait_drain();
        finish_test("branches");

        run_group(OP_JAL, OP_AUIPC, 150, 0);
        wait_drain();
        finish_test("jumps and upper immediates");

        bp_mode <= 1'b1;
        run_group(OP_ADD, OP_AUIPC, 400, 0);
        bp_mode <= 1'b0;
        wait_drain();
        finish_test("back-pressure");

        // Reset with instructions in flight, then a sparse stream with ready high.
        bp_mode <= 1'b1;
        run_group(OP_ADD, OP_AUIPC, 20, 0);
        rst_i <= 1'b1;
        repeat (3) @(posedge i_clk);
        rst_i   <= 1'b0;
        bp_mode <= 1'b0;
        run_group(OP_ADD, OP_AUIPC, 150, 3);
        wait_drain();
        finish_test("reset and latency");

        $display("total: %0d results checked, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0 && chk_cnt > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
